// ==== design/issue_chan_if.sv ====
interface issue_chan_if
  import issue_pkg::*;
();

  logic         valid;
  logic         ready;
  issue_instr_t instr;
  word_t        rs1_val;
  word_t        rs2_val;

  // Scoreboard side
  modport src(output valid, output instr, output rs1_val, output rs2_val, input ready);

  // Dispatch side
  modport dst(input valid, input instr, input rs1_val, input rs2_val, output ready);

endinterface

// ==== design/issue_dispatch.sv ====
module issue_dispatch
  import issue_pkg::*;
(
  input  logic         clk_core,
  input  logic         rst_core_n,

  input  logic         flush_i,

  issue_chan_if.dst    in,

  output logic         alu_valid_o,
  output alu_payload_t alu_payload_o,
  input  logic         alu_ready_i,

  output logic         mem_valid_o,
  output mem_payload_t mem_payload_o,
  input  logic         mem_ready_i
);

  logic         is_alu;
  logic         leaving;
  logic         take;
  alu_payload_t alu_d;
  mem_payload_t mem_d;

  assign is_alu = (in.instr.unit == UNIT_ALU);

  // Held item moves into its skid buffer this cycle
  assign leaving = (alu_valid_o && alu_ready_i) || (mem_valid_o && mem_ready_i);
  assign in.ready = (!alu_valid_o && !mem_valid_o) || leaving;
  assign take = in.valid && in.ready;

  always_comb begin
    alu_d.alu_op    = in.instr.alu_op;
    alu_d.writes_rd = in.instr.writes_rd;
    alu_d.rd_addr   = in.instr.rd_addr;
    alu_d.rs1_val   = in.rs1_val;
    alu_d.rs2_val   = in.rs2_val;
    alu_d.imm       = in.instr.imm;
    alu_d.pc        = in.instr.pc;

    mem_d.is_store   = in.instr.is_store;
    mem_d.writes_rd  = in.instr.writes_rd;
    mem_d.rd_addr    = in.instr.rd_addr;
    mem_d.base       = in.rs1_val;
    mem_d.store_data = in.rs2_val;
    mem_d.imm        = in.instr.imm;
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      alu_valid_o <= 1'b0;
      mem_valid_o <= 1'b0;
    end else if (flush_i) begin
      alu_valid_o <= 1'b0;
      mem_valid_o <= 1'b0;
    end else if (take) begin
      alu_valid_o <= is_alu;
      mem_valid_o <= !is_alu;
    end else begin
      if (alu_ready_i) alu_valid_o <= 1'b0;
      if (mem_ready_i) mem_valid_o <= 1'b0;
    end
  end

  // Only the selected channel loads, the other keeps its old payload
  always_ff @(posedge clk_core) begin
    if (take && is_alu) alu_payload_o <= alu_d;
    if (take && !is_alu) mem_payload_o <= mem_d;
  end

  a_one_channel: assert property (@(posedge clk_core) disable iff (!rst_core_n)
    !(alu_valid_o && mem_valid_o))
    else $error("both channel valids set in dispatch");

  a_alu_hold: assert property (@(posedge clk_core) disable iff (!rst_core_n)
    alu_valid_o && !alu_ready_i && !flush_i |=> alu_valid_o && $stable(alu_payload_o))
    else $error("ALU payload changed under back-pressure");

  a_mem_hold: assert property (@(posedge clk_core) disable iff (!rst_core_n)
    mem_valid_o && !mem_ready_i && !flush_i |=> mem_valid_o && $stable(mem_payload_o))
    else $error("memory payload changed under back-pressure");

endmodule

// ==== design/issue_pkg.sv ====
package issue_pkg;

  localparam int XLEN = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS = 32;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [XLEN-1:0] word_t;
  typedef logic [NUM_REGS-1:0] reg_mask_t;

  // x0 never holds a value and is never pending
  localparam reg_addr_t REG_ZERO = '0;

  typedef enum logic [0:0] {
    UNIT_ALU = 1'b0,
    UNIT_MEM = 1'b1
  } unit_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5,
    ALU_SRL = 3'd6,
    ALU_SLT = 3'd7
  } alu_op_e;

  // Decoded instruction as delivered by decode
  typedef struct packed {
    unit_e     unit;
    alu_op_e   alu_op;
    logic      is_store;
    logic      writes_rd;
    reg_addr_t rd_addr;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     imm;
    word_t     pc;
  } issue_instr_t;

  typedef struct packed {
    alu_op_e   alu_op;
    logic      writes_rd;
    reg_addr_t rd_addr;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm;
    word_t     pc;
  } alu_payload_t;

  // Base and store data are the rs1 and rs2 values
  typedef struct packed {
    logic      is_store;
    logic      writes_rd;
    reg_addr_t rd_addr;
    word_t     base;
    word_t     store_data;
    word_t     imm;
  } mem_payload_t;

endpackage

// ==== design/issue_regfile.sv ====
module issue_regfile
  import issue_pkg::*;
(
  input  logic      clk_core,
  input  logic      rst_core_n,

  input  reg_addr_t rd_addr1_i,
  input  reg_addr_t rd_addr2_i,
  output word_t     rd_data1_o,
  output word_t     rd_data2_o,

  input  logic      wr_en_i,
  input  reg_addr_t wr_addr_i,
  input  word_t     wr_data_i
);

  // No storage behind x0
  word_t regs [1:NUM_REGS-1];

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && (wr_addr_i != REG_ZERO)) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  // Combinational reads, x0 reads as zero
  always_comb begin
    rd_data1_o = '0;
    rd_data2_o = '0;
    if (rd_addr1_i != REG_ZERO) begin
      rd_data1_o = regs[rd_addr1_i];
    end
    if (rd_addr2_i != REG_ZERO) begin
      rd_data2_o = regs[rd_addr2_i];
    end
  end

endmodule

// ==== design/issue_scoreboard.sv ====
module issue_scoreboard
  import issue_pkg::*;
(
  input  logic         clk_core,
  input  logic         rst_core_n,

  input  logic         flush_i,

  input  logic         instr_valid_i,
  input  issue_instr_t instr_i,
  output logic         instr_ready_o,

  input  logic         wb_en_i,
  input  reg_addr_t    wb_addr_i,

  output reg_addr_t    rs1_addr_o,
  output reg_addr_t    rs2_addr_o,
  input  word_t        rs1_val_i,
  input  word_t        rs2_val_i,

  issue_chan_if.src    out
);

  reg_mask_t pending_q;
  reg_mask_t pending_d;
  logic      hazard;
  logic      out_free;
  logic      accept;

  assign rs1_addr_o = instr_i.rs1_addr;
  assign rs2_addr_o = instr_i.rs2_addr;

  // pending_q[0] is never set, so x0 needs no special case here
  assign hazard = pending_q[instr_i.rs1_addr] || pending_q[instr_i.rs2_addr] ||
                  (instr_i.writes_rd && pending_q[instr_i.rd_addr]);

  // Output register empty or draining this cycle
  assign out_free = !out.valid || out.ready;

  assign instr_ready_o = !flush_i && out_free && !hazard;
  assign accept = instr_valid_i && instr_ready_o;

  // Clear from writeback first so that a set on the same register wins
  always_comb begin
    pending_d = pending_q;
    if (wb_en_i) begin
      pending_d[wb_addr_i] = 1'b0;
    end
    if (accept && instr_i.writes_rd && (instr_i.rd_addr != REG_ZERO)) begin
      pending_d[instr_i.rd_addr] = 1'b1;
    end
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      pending_q <= '0;
      out.valid <= 1'b0;
    end else if (flush_i) begin
      pending_q <= '0;
      out.valid <= 1'b0;
    end else begin
      pending_q <= pending_d;
      if (accept) begin
        out.valid <= 1'b1;
      end else if (out.ready) begin
        out.valid <= 1'b0;
      end
    end
  end

  // First pipeline register, payload only
  always_ff @(posedge clk_core) begin
    if (accept) begin
      out.instr   <= instr_i;
      out.rs1_val <= rs1_val_i;
      out.rs2_val <= rs2_val_i;
    end
  end

  // A register whose writeback is still on its way counts as pending
  a_no_pending_source: assert property (@(posedge clk_core) disable iff (!rst_core_n)
    accept && wb_en_i && (wb_addr_i != REG_ZERO) |->
      (wb_addr_i != instr_i.rs1_addr) && (wb_addr_i != instr_i.rs2_addr))
    else $error("instruction accepted while a source register is pending");

endmodule

// ==== design/issue_stage.sv ====
module issue_stage
  import issue_pkg::*;
(
  input  logic         clk_core,
  input  logic         rst_core_n,

  input  logic         instr_valid_i,
  output logic         instr_ready_o,
  input  issue_instr_t instr_i,

  output logic         alu_valid_o,
  input  logic         alu_ready_i,
  output alu_payload_t alu_payload_o,

  output logic         mem_valid_o,
  input  logic         mem_ready_i,
  output mem_payload_t mem_payload_o,

  input  logic         wb_en_i,
  input  reg_addr_t    wb_addr_i,
  input  word_t        wb_data_i,

  input  logic         flush_req_i,
  output logic         flush_ack_o
);

  reg_addr_t    rs1_addr, rs2_addr;
  word_t        rs1_val, rs2_val;

  // Dispatch to skid buffer links
  logic         disp_alu_valid, disp_alu_ready;
  logic         disp_mem_valid, disp_mem_ready;
  alu_payload_t disp_alu_payload;
  mem_payload_t disp_mem_payload;

  issue_chan_if u_chan ();

  issue_regfile u_regfile (
    .clk_core   (clk_core),
    .rst_core_n (rst_core_n),
    .rd_addr1_i (rs1_addr),
    .rd_addr2_i (rs2_addr),
    .rd_data1_o (rs1_val),
    .rd_data2_o (rs2_val),
    .wr_en_i    (wb_en_i),
    .wr_addr_i  (wb_addr_i),
    .wr_data_i  (wb_data_i)
  );

  issue_scoreboard u_scoreboard (
    .clk_core      (clk_core),
    .rst_core_n    (rst_core_n),
    .flush_i       (flush_req_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_ready_o (instr_ready_o),
    .wb_en_i       (wb_en_i),
    .wb_addr_i     (wb_addr_i),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rs1_val_i     (rs1_val),
    .rs2_val_i     (rs2_val),
    .out           (u_chan.src)
  );

  issue_dispatch u_dispatch (
    .clk_core      (clk_core),
    .rst_core_n    (rst_core_n),
    .flush_i       (flush_req_i),
    .in            (u_chan.dst),
    .alu_valid_o   (disp_alu_valid),
    .alu_payload_o (disp_alu_payload),
    .alu_ready_i   (disp_alu_ready),
    .mem_valid_o   (disp_mem_valid),
    .mem_payload_o (disp_mem_payload),
    .mem_ready_i   (disp_mem_ready)
  );

  skid_buffer #(.T(alu_payload_t)) u_alu_skid (
    .clk_core   (clk_core),
    .rst_core_n (rst_core_n),
    .flush_i    (flush_req_i),
    .valid_i    (disp_alu_valid),
    .ready_o    (disp_alu_ready),
    .data_i     (disp_alu_payload),
    .valid_o    (alu_valid_o),
    .ready_i    (alu_ready_i),
    .data_o     (alu_payload_o)
  );

  skid_buffer #(.T(mem_payload_t)) u_mem_skid (
    .clk_core   (clk_core),
    .rst_core_n (rst_core_n),
    .flush_i    (flush_req_i),
    .valid_i    (disp_mem_valid),
    .ready_o    (disp_mem_ready),
    .data_i     (disp_mem_payload),
    .valid_o    (mem_valid_o),
    .ready_i    (mem_ready_i),
    .data_o     (mem_payload_o)
  );

  // Acknowledge trails the request by one cycle on both edges
  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      flush_ack_o <= 1'b0;
    end else begin
      flush_ack_o <= flush_req_i;
    end
  end

endmodule

// ==== design/skid_buffer.sv ====
module skid_buffer
  import issue_pkg::*;
#(
  parameter type T = word_t
) (
  input  logic clk_core,
  input  logic rst_core_n,

  input  logic flush_i,

  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,

  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  // Entry 0 drives the output, entry 1 catches the item in flight
  logic v0_q, v1_q;
  logic v0_d, v1_d;
  T     d0_q, d1_q;
  logic wr_en, rd_en;
  logic ld0_in, ld0_skid, ld1;

  // Registered ready, entry 1 only fills while entry 0 is full
  assign ready_o = !v1_q;
  assign valid_o = v0_q;
  assign data_o  = d0_q;

  assign wr_en = valid_i && ready_o;
  assign rd_en = v0_q && ready_i;

  always_comb begin
    v0_d     = v0_q;
    v1_d     = v1_q;
    ld0_in   = 1'b0;
    ld0_skid = 1'b0;
    ld1      = 1'b0;
    if (rd_en) begin
      if (v1_q) begin
        ld0_skid = 1'b1;
        v1_d     = 1'b0;
      end else if (wr_en) begin
        ld0_in = 1'b1;
      end else begin
        v0_d = 1'b0;
      end
    end else if (wr_en) begin
      if (v0_q) begin
        ld1  = 1'b1;
        v1_d = 1'b1;
      end else begin
        ld0_in = 1'b1;
        v0_d   = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      v0_q <= 1'b0;
      v1_q <= 1'b0;
    end else if (flush_i) begin
      v0_q <= 1'b0;
      v1_q <= 1'b0;
    end else begin
      v0_q <= v0_d;
      v1_q <= v1_d;
    end
  end

  always_ff @(posedge clk_core) begin
    if (ld0_in) d0_q <= data_i;
    else if (ld0_skid) d0_q <= d1_q;
    if (ld1) d1_q <= data_i;
  end

  // A full, stalled buffer keeps both entries untouched
  a_no_write_full: assert property (@(posedge clk_core) disable iff (!rst_core_n)
    v0_q && v1_q && !ready_i && !flush_i |=>
      v0_q && v1_q && $stable(d0_q) && $stable(d1_q))
    else $error("write into full skid buffer");

endmodule

// ==== list.f ====
design/issue_pkg.sv
design/issue_chan_if.sv
design/issue_regfile.sv
design/issue_scoreboard.sv
design/issue_dispatch.sv
design/skid_buffer.sv
design/issue_stage.sv
tb/tb_clock_gen.sv
tb/tb_issue_stage.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_issue_stage \
  -f list.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_issue_stage)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

// ==== tb/tb_clock_gen.sv ====
module tb_clock_gen (
  output logic clk_core,
  output logic rst_core_n
);

  initial begin
    clk_core = 1'b0;
    forever #50 clk_core = ~clk_core;
  end

  // Reset held for 8 rising edges, released just after the last one
  initial begin
    rst_core_n = 1'b0;
    repeat (8) @(posedge clk_core);
    #10 rst_core_n = 1'b1;
  end

endmodule

// ==== tb/tb_issue_stage.sv ====
module tb_issue_stage
  import issue_pkg::*;
();

  localparam int NUM_INSTR = 300;
  localparam int SPLIT = 200;
  localparam int CLK_PERIOD = 100;

  logic clk_core, rst_core_n;
  logic instr_valid_i, instr_ready_o;
  issue_instr_t instr_i;
  logic alu_valid_o, alu_ready_i, mem_valid_o, mem_ready_i;
  alu_payload_t alu_payload_o;
  mem_payload_t mem_payload_o;
  logic wb_en_i;
  reg_addr_t wb_addr_i;
  word_t wb_data_i;
  logic flush_req_i, flush_ack_o;

  // Program and its program-order results
  issue_instr_t prog [0:NUM_INSTR-1];
  word_t result [0:NUM_INSTR-1];
  int prod1 [0:NUM_INSTR-1];
  int prod2 [0:NUM_INSTR-1];
  bit wb_done [0:NUM_INSTR-1];

  alu_payload_t alu_exp_q[$];
  mem_payload_t mem_exp_q[$];
  int alu_idx_q[$];
  int mem_idx_q[$];

  // Writebacks waiting for their due cycle
  reg_addr_t wb_addr_q[$];
  word_t wb_data_q[$];
  int wb_idx_q[$];
  int wb_due_q[$];

  int err_cnt = 0;
  int done_cnt = 0;
  int cyc = 0;
  bit hold_low = 1'b0;

  tb_clock_gen u_clock_gen (.clk_core(clk_core), .rst_core_n(rst_core_n));

  issue_stage u_issue_stage (
    .clk_core(clk_core), .rst_core_n(rst_core_n),
    .instr_valid_i(instr_valid_i), .instr_ready_o(instr_ready_o), .instr_i(instr_i),
    .alu_valid_o(alu_valid_o), .alu_ready_i(alu_ready_i), .alu_payload_o(alu_payload_o),
    .mem_valid_o(mem_valid_o), .mem_ready_i(mem_ready_i), .mem_payload_o(mem_payload_o),
    .wb_en_i(wb_en_i), .wb_addr_i(wb_addr_i), .wb_data_i(wb_data_i),
    .flush_req_i(flush_req_i), .flush_ack_o(flush_ack_o)
  );

  task automatic build_program();
    word_t model [0:NUM_REGS-1];
    int last_wr [0:NUM_REGS-1];
    issue_instr_t ins;
    alu_payload_t ap;
    mem_payload_t mp;
    word_t a, b;
    for (int r = 0; r < NUM_REGS; r++) begin
      model[r] = '0;
      last_wr[r] = -1;
    end
    for (int i = 0; i < NUM_INSTR; i++) begin
      ins.unit = ($urandom_range(1) == 1) ? UNIT_MEM : UNIT_ALU;
      ins.alu_op = alu_op_e'(3'($urandom_range(7)));
      ins.is_store = (ins.unit == UNIT_MEM) && ($urandom_range(1) == 1);
      ins.writes_rd = (ins.unit == UNIT_MEM) ? !ins.is_store : ($urandom_range(7) != 0);
      // Only x0..x7 so that dependencies are frequent
      ins.rd_addr = reg_addr_t'($urandom_range(7));
      ins.rs1_addr = reg_addr_t'($urandom_range(7));
      ins.rs2_addr = reg_addr_t'($urandom_range(7));
      ins.imm = $urandom();
      ins.pc = word_t'(32'h1000 + 4 * i);
      a = model[ins.rs1_addr];
      b = model[ins.rs2_addr];
      prod1[i] = last_wr[ins.rs1_addr];
      prod2[i] = last_wr[ins.rs2_addr];
      wb_done[i] = 1'b0;
      if (ins.unit == UNIT_ALU) begin
        ap.alu_op = ins.alu_op;
        ap.writes_rd = ins.writes_rd;
        ap.rd_addr = ins.rd_addr;
        ap.rs1_val = a;
        ap.rs2_val = b;
        ap.imm = ins.imm;
        ap.pc = ins.pc;
        alu_exp_q.push_back(ap);
        alu_idx_q.push_back(i);
        result[i] = a + b + ins.imm;
      end else begin
        mp.is_store = ins.is_store;
        mp.writes_rd = ins.writes_rd;
        mp.rd_addr = ins.rd_addr;
        mp.base = a;
        mp.store_data = b;
        mp.imm = ins.imm;
        mem_exp_q.push_back(mp);
        mem_idx_q.push_back(i);
        result[i] = ~(a + ins.imm);
      end
      if (ins.writes_rd && ins.rd_addr != REG_ZERO) begin
        model[ins.rd_addr] = result[i];
        last_wr[ins.rd_addr] = i;
      end
      prog[i] = ins;
    end
  endtask

  // Called at +10 after an edge, returns at +10 after the transfer edge
  task automatic send_instr(input issue_instr_t ins);
    instr_valid_i = 1'b1;
    instr_i = ins;
    @(negedge clk_core);
    while (!instr_ready_o) @(negedge clk_core);
    @(posedge clk_core);
    #10;
    instr_valid_i = 1'b0;
  endtask

  task automatic run_program(input int first, input int last);
    for (int i = first; i < last; i++) begin
      if ($urandom_range(4) == 0) begin
        @(posedge clk_core);
        #10;
      end
      send_instr(prog[i]);
    end
  endtask

  task automatic wait_drain(input int count);
    while (done_cnt < count || wb_due_q.size() != 0) @(negedge clk_core);
    @(posedge clk_core);
    #10;
  endtask

  // Producer check, then schedule this instruction's own writeback
  task automatic note_issue(input int idx);
    if (prod1[idx] >= 0 && !wb_done[prod1[idx]]) begin
      $display("Instruction %0d issued before writeback of %0d", idx, prod1[idx]);
      err_cnt++;
    end
    if (prod2[idx] >= 0 && !wb_done[prod2[idx]]) begin
      $display("Instruction %0d issued before writeback of %0d", idx, prod2[idx]);
      err_cnt++;
    end
    if (prog[idx].writes_rd) begin
      wb_addr_q.push_back(prog[idx].rd_addr);
      wb_data_q.push_back(result[idx]);
      wb_idx_q.push_back(idx);
      wb_due_q.push_back(cyc + 1 + int'($urandom_range(6)));
    end
    done_cnt++;
  endtask

  task automatic take_alu();
    alu_payload_t exp;
    int idx;
    if (alu_exp_q.size() == 0) begin
      $display("Unexpected payload on the ALU channel at time %0t", $time);
      err_cnt++;
    end else begin
      exp = alu_exp_q.pop_front();
      idx = alu_idx_q.pop_front();
      if (alu_payload_o !== exp) begin
        $display("** Error: alu_payload_o = %h, expected %h", alu_payload_o, exp);
        err_cnt++;
      end
      note_issue(idx);
    end
  endtask

  task automatic take_mem();
    mem_payload_t exp;
    int idx;
    if (mem_exp_q.size() == 0) begin
      $display("Unexpected payload on the memory channel at time %0t", $time);
      err_cnt++;
    end else begin
      exp = mem_exp_q.pop_front();
      idx = mem_idx_q.pop_front();
      if (mem_payload_o !== exp) begin
        $display("** Error: mem_payload_o = %h, expected %h", mem_payload_o, exp);
        err_cnt++;
      end
      note_issue(idx);
    end
  endtask

  task automatic flush_test();
    issue_instr_t ins;
    @(negedge clk_core);
    hold_low = 1'b1;
    @(posedge clk_core);
    #10;
    // Marked instructions that write nothing, all of them get discarded
    for (int k = 0; k < 4; k++) begin
      ins = '0;
      ins.unit = ($urandom_range(1) == 1) ? UNIT_MEM : UNIT_ALU;
      ins.is_store = (ins.unit == UNIT_MEM);
      ins.rs1_addr = reg_addr_t'($urandom_range(7));
      ins.rs2_addr = reg_addr_t'($urandom_range(7));
      ins.imm = word_t'(32'hdead_0000 + k);
      ins.pc = word_t'(32'hdead_0000 + k);
      send_instr(ins);
    end
    repeat (2) @(posedge clk_core);
    #10;
    flush_req_i = 1'b1;
    @(negedge clk_core);
    if (instr_ready_o !== 1'b0) begin
      $display("** Error: instr_ready_o = %h, expected %h", instr_ready_o, 1'b0);
      err_cnt++;
    end
    if (flush_ack_o !== 1'b0) begin
      $display("** Error: flush_ack_o = %h, expected %h", flush_ack_o, 1'b0);
      err_cnt++;
    end
    // Acknowledge is up one edge after the request
    @(negedge clk_core);
    if (flush_ack_o !== 1'b1) begin
      $display("** Error: flush_ack_o = %h, expected %h", flush_ack_o, 1'b1);
      err_cnt++;
    end
    @(posedge clk_core);
    #10;
    flush_req_i = 1'b0;
    @(negedge clk_core);
    if (flush_ack_o !== 1'b1) begin
      $display("** Error: flush_ack_o = %h, expected %h", flush_ack_o, 1'b1);
      err_cnt++;
    end
    @(negedge clk_core);
    if (flush_ack_o !== 1'b0) begin
      $display("** Error: flush_ack_o = %h, expected %h", flush_ack_o, 1'b0);
      err_cnt++;
    end
    if (alu_valid_o !== 1'b0) begin
      $display("** Error: alu_valid_o = %h, expected %h", alu_valid_o, 1'b0);
      err_cnt++;
    end
    if (mem_valid_o !== 1'b0) begin
      $display("** Error: mem_valid_o = %h, expected %h", mem_valid_o, 1'b0);
      err_cnt++;
    end
    hold_low = 1'b0;
    @(posedge clk_core);
    #10;
  endtask

  // Execution units and writeback, driven 10 after each rising edge
  initial begin
    int sel;
    alu_ready_i = 1'b0;
    mem_ready_i = 1'b0;
    wb_en_i = 1'b0;
    wb_addr_i = '0;
    wb_data_i = '0;
    forever begin
      @(posedge clk_core);
      #10;
      cyc++;
      alu_ready_i = hold_low ? 1'b0 : ($urandom_range(3) != 0);
      mem_ready_i = hold_low ? 1'b0 : ($urandom_range(3) != 0);
      sel = -1;
      foreach (wb_due_q[k]) begin
        if (sel < 0 && wb_due_q[k] <= cyc) sel = k;
      end
      wb_en_i = (sel >= 0);
      if (sel >= 0) begin
        wb_addr_i = wb_addr_q[sel];
        wb_data_i = wb_data_q[sel];
        wb_done[wb_idx_q[sel]] = 1'b1;
        wb_addr_q.delete(sel);
        wb_data_q.delete(sel);
        wb_idx_q.delete(sel);
        wb_due_q.delete(sel);
      end
    end
  end

  // Channel monitor, transfers happen at the following rising edge
  initial begin
    bit alu_hold, mem_hold;
    alu_payload_t alu_prev;
    mem_payload_t mem_prev;
    alu_hold = 1'b0;
    mem_hold = 1'b0;
    forever begin
      @(negedge clk_core);
      if (rst_core_n) begin
        if (alu_hold && (alu_valid_o !== 1'b1 || alu_payload_o !== alu_prev)) begin
          $display("ALU channel changed under back-pressure at time %0t", $time);
          err_cnt++;
        end
        if (mem_hold && (mem_valid_o !== 1'b1 || mem_payload_o !== mem_prev)) begin
          $display("Memory channel changed under back-pressure at time %0t", $time);
          err_cnt++;
        end
        if (alu_valid_o && alu_ready_i) take_alu();
        if (mem_valid_o && mem_ready_i) take_mem();
        alu_hold = alu_valid_o && !alu_ready_i && !flush_req_i;
        mem_hold = mem_valid_o && !mem_ready_i && !flush_req_i;
        alu_prev = alu_payload_o;
        mem_prev = mem_payload_o;
      end
    end
  end

  initial begin
    #(NUM_INSTR * 40 * CLK_PERIOD);
    $display("Watchdog expired with %0d of %0d instructions seen", done_cnt, NUM_INSTR);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    void'($urandom(33));
    instr_valid_i = 1'b0;
    instr_i = '0;
    flush_req_i = 1'b0;
    build_program();
    wait (rst_core_n === 1'b1);
    @(negedge clk_core);
    if (alu_valid_o !== 1'b0) begin
      $display("** Error: alu_valid_o = %h, expected %h", alu_valid_o, 1'b0);
      err_cnt++;
    end
    if (mem_valid_o !== 1'b0) begin
      $display("** Error: mem_valid_o = %h, expected %h", mem_valid_o, 1'b0);
      err_cnt++;
    end
    if (flush_ack_o !== 1'b0) begin
      $display("** Error: flush_ack_o = %h, expected %h", flush_ack_o, 1'b0);
      err_cnt++;
    end
    if (instr_ready_o !== 1'b1) begin
      $display("** Error: instr_ready_o = %h, expected %h", instr_ready_o, 1'b1);
      err_cnt++;
    end
    @(posedge clk_core);
    #10;
    run_program(0, SPLIT);
    wait_drain(SPLIT);
    flush_test();
    run_program(SPLIT, NUM_INSTR);
    wait_drain(NUM_INSTR);
    repeat (4) @(posedge clk_core);
    $display("Run finished with %0d errors, %0d of %0d instructions checked",
             err_cnt, done_cnt, NUM_INSTR);
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
